//--- logic/id_pkg.sv
// Shared widths, field positions, encodings and pipeline structs, imported by every decode-stage file
package id_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int unsigned XLEN = 32;

  // Data or address word
  typedef logic [XLEN-1:0] word_t;

  // Register file index
  typedef logic [4:0] rf_addr_t;

  // Instruction field positions
  localparam int unsigned RS1_MSB    = 19;
  localparam int unsigned RS1_LSB    = 15;
  localparam int unsigned RS2_MSB    = 24;
  localparam int unsigned RS2_LSB    = 20;
  localparam int unsigned RD_MSB     = 11;
  localparam int unsigned RD_LSB     = 7;
  localparam int unsigned OPCODE_MSB = 6;
  localparam int unsigned OPCODE_LSB = 0;

  ////////////////////
  // Opcodes
  ////////////////////

  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_JALR   = 7'h67;

  // Link offset for JAL and JALR
  localparam word_t PC_INCR = 32'd4;

  ////////////////////
  // Encodings
  ////////////////////

  // ALU operation, compares share the encoding space
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR,  ALU_AND, ALU_EQ,  ALU_NE,  ALU_LT,   ALU_GE,  ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO, OP_A_NONE} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM, OP_B_PCINCR, OP_B_NONE} op_b_sel_e;
  typedef enum logic [1:0] {OP_C_REG, OP_C_BCH, OP_C_NONE} op_c_sel_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

  // Forwarding source picked by the hazard controller
  typedef enum logic [1:0] {FW_REGFILE, FW_EX, FW_WB} fw_sel_e;

  // Memory access size as seen by the LSU
  typedef enum logic [1:0] {LSU_BYTE, LSU_HALF, LSU_WORD} lsu_size_e;

  ////////////////////
  // Pipeline structs
  ////////////////////

  // Fetched instruction and its address
  typedef struct packed {
    word_t pc;
    word_t instr;
  } if_id_t;

  // Forwarding controls and data
  typedef struct packed {
    fw_sel_e a_sel;
    fw_sel_e b_sel;
    fw_sel_e jalr_sel;
    word_t   ex_data;
    word_t   wb_data;
  } byp_t;

  // Decoder result
  typedef struct packed {
    logic      alu_en;
    alu_op_e   alu_op;
    logic      bch;
    logic      jmp;
    logic      jmpr;
    logic      lsu_en;
    logic      lsu_we;
    lsu_size_e lsu_size;
    logic      lsu_sext;
    logic      rf_we;
    rf_addr_t  rf_waddr;
    logic      illegal;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    op_c_sel_e op_c_sel;
    imm_sel_e  imm_sel;
    word_t     imm;
  } dec_ctrl_t;

  // Registered stage output towards EX
  typedef struct packed {
    logic      alu_en;
    alu_op_e   alu_op;
    logic      bch;
    logic      jmp;
    logic      lsu_en;
    logic      lsu_we;
    lsu_size_e lsu_size;
    logic      lsu_sext;
    logic      rf_we;
    rf_addr_t  rf_waddr;
    logic      illegal;
    word_t     pc;
    word_t     operand_a;
    word_t     operand_b;
    word_t     operand_c;
  } id_ex_t;

endpackage

//--- logic/id_decoder.sv
// RV32I instruction decoder, turns an instruction word into control fields and the immediate
`timescale 1ns/1ps

module id_decoder import id_pkg::*; (
  input  word_t      instr_i,
  output dec_ctrl_t  ctrl_o,
  output logic [1:0] rf_re_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Immediates of every format
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  assign opcode = instr_i[OPCODE_MSB:OPCODE_LSB];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  ////////////////////
  // Immediates
  ////////////////////

  // Sign bit is always instr[31]
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  // Upper immediate, low bits zero filled
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin : decode
    // Defaults describe a no-op with no unit enabled
    ctrl_o.alu_en   = 1'b0;
    ctrl_o.alu_op   = ALU_ADD;
    ctrl_o.bch      = 1'b0;
    ctrl_o.jmp      = 1'b0;
    ctrl_o.jmpr     = 1'b0;
    ctrl_o.lsu_en   = 1'b0;
    ctrl_o.lsu_we   = 1'b0;
    ctrl_o.lsu_size = LSU_WORD;
    ctrl_o.lsu_sext = 1'b0;
    ctrl_o.rf_we    = 1'b0;
    ctrl_o.rf_waddr = instr_i[RD_MSB:RD_LSB];
    ctrl_o.illegal  = 1'b0;
    ctrl_o.op_a_sel = OP_A_NONE;
    ctrl_o.op_b_sel = OP_B_NONE;
    ctrl_o.op_c_sel = OP_C_NONE;
    ctrl_o.imm_sel  = IMM_I;
    ctrl_o.imm      = imm_i;
    rf_re_o         = 2'b00;

    case (opcode)
      // Register-register and register-immediate ALU forms
      OPC_OP, OPC_OP_IMM: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_REG;
        rf_re_o[0]      = 1'b1;
        if (opcode == OPC_OP) begin
          ctrl_o.op_b_sel = OP_B_REG;
          rf_re_o[1]      = 1'b1;
          // Only SUB and SRA may carry the alternate funct7
          if (funct7 == 7'b0100000) begin
            ctrl_o.illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
          end else begin
            ctrl_o.illegal = (funct7 != 7'b0000000);
          end
        end else begin
          ctrl_o.op_b_sel = OP_B_IMM;
          // Shift amounts need a clean upper field
          if (funct3 == 3'b001) begin
            ctrl_o.illegal = (funct7 != 7'b0000000);
          end else if (funct3 == 3'b101) begin
            ctrl_o.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        end
        case (funct3)
          3'b000: begin
            // ADDI has no subtract form
            if (opcode == OPC_OP && funct7[5]) ctrl_o.alu_op = ALU_SUB;
            else                               ctrl_o.alu_op = ALU_ADD;
          end
          3'b001: ctrl_o.alu_op = ALU_SLL;
          3'b010: ctrl_o.alu_op = ALU_SLT;
          3'b011: ctrl_o.alu_op = ALU_SLTU;
          3'b100: ctrl_o.alu_op = ALU_XOR;
          3'b101: ctrl_o.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110: ctrl_o.alu_op = ALU_OR;
          default: ctrl_o.alu_op = ALU_AND;
        endcase
      end

      // Upper immediates go through the adder
      OPC_LUI, OPC_AUIPC: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_sel  = IMM_U;
      end

      OPC_LOAD: begin
        ctrl_o.lsu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_REG;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.lsu_size = lsu_size_e'(funct3[1:0]);
        // LBU and LHU zero extend
        ctrl_o.lsu_sext = ~funct3[2];
        rf_re_o[0]      = 1'b1;
        ctrl_o.illegal  = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end

      OPC_STORE: begin
        ctrl_o.lsu_en   = 1'b1;
        ctrl_o.lsu_we   = 1'b1;
        ctrl_o.op_a_sel = OP_A_REG;
        ctrl_o.op_b_sel = OP_B_IMM;
        // Store data rides on operand C
        ctrl_o.op_c_sel = OP_C_REG;
        ctrl_o.imm_sel  = IMM_S;
        ctrl_o.lsu_size = lsu_size_e'(funct3[1:0]);
        rf_re_o         = 2'b11;
        ctrl_o.illegal  = funct3[2] || (funct3[1:0] == 2'b11);
      end

      OPC_BRANCH: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.bch      = 1'b1;
        ctrl_o.op_a_sel = OP_A_REG;
        ctrl_o.op_b_sel = OP_B_REG;
        ctrl_o.op_c_sel = OP_C_BCH;
        ctrl_o.imm_sel  = IMM_B;
        rf_re_o         = 2'b11;
        case (funct3)
          3'b000: ctrl_o.alu_op = ALU_EQ;
          3'b001: ctrl_o.alu_op = ALU_NE;
          3'b100: ctrl_o.alu_op = ALU_LT;
          3'b101: ctrl_o.alu_op = ALU_GE;
          3'b110: ctrl_o.alu_op = ALU_LTU;
          3'b111: ctrl_o.alu_op = ALU_GEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end

      // Jumps compute the link address pc + 4 in the ALU
      OPC_JAL, OPC_JALR: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.jmp      = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.op_b_sel = OP_B_PCINCR;
        if (opcode == OPC_JAL) begin
          ctrl_o.imm_sel = IMM_J;
        end else begin
          ctrl_o.jmpr    = 1'b1;
          rf_re_o[0]     = 1'b1;
          ctrl_o.illegal = (funct3 != 3'b000);
        end
      end

      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal encodings leave no unit enabled and keep the operand registers
    if (ctrl_o.illegal) begin
      ctrl_o.alu_en   = 1'b0;
      ctrl_o.bch      = 1'b0;
      ctrl_o.jmp      = 1'b0;
      ctrl_o.jmpr     = 1'b0;
      ctrl_o.lsu_en   = 1'b0;
      ctrl_o.lsu_we   = 1'b0;
      ctrl_o.rf_we    = 1'b0;
      ctrl_o.op_a_sel = OP_A_NONE;
      ctrl_o.op_b_sel = OP_B_NONE;
      ctrl_o.op_c_sel = OP_C_NONE;
      // Both sources are read so a later handler sees them
      rf_re_o         = 2'b11;
    end

    // Immediate of the chosen format
    case (ctrl_o.imm_sel)
      IMM_S:   ctrl_o.imm = imm_s;
      IMM_B:   ctrl_o.imm = imm_b;
      IMM_U:   ctrl_o.imm = imm_u;
      IMM_J:   ctrl_o.imm = imm_j;
      default: ctrl_o.imm = imm_i;
    endcase
  end

endmodule

//--- logic/id_operand_sel.sv
// Operand forwarding and selection plus branch and jump target arithmetic for the decode stage
`timescale 1ns/1ps

module id_operand_sel import id_pkg::*; (
  input  word_t     pc_i,
  input  dec_ctrl_t ctrl_i,
  input  word_t     rs1_data_i,
  input  word_t     rs2_data_i,
  input  byp_t      byp_i,
  output word_t     operand_a_o,
  output word_t     operand_b_o,
  output word_t     operand_c_o,
  output word_t     jmp_target_o
);

  // Forwarded source values
  word_t rs1_fw;
  word_t rs2_fw;
  word_t jalr_fw;

  // Target adders
  word_t bch_target;
  word_t jalr_sum;

  // Pick register file, EX result or WB result
  function automatic word_t fw_mux(
    input fw_sel_e sel,
    input word_t   rf_data,
    input word_t   ex_data,
    input word_t   wb_data
  );
    word_t res;
    case (sel)
      FW_EX:   res = ex_data;
      FW_WB:   res = wb_data;
      default: res = rf_data;
    endcase
    return res;
  endfunction

  ////////////////////
  // Forwarding
  ////////////////////

  assign rs1_fw  = fw_mux(byp_i.a_sel, rs1_data_i, byp_i.ex_data, byp_i.wb_data);
  assign rs2_fw  = fw_mux(byp_i.b_sel, rs2_data_i, byp_i.ex_data, byp_i.wb_data);

  // JALR base has its own select since the target leaves ID early
  assign jalr_fw = fw_mux(byp_i.jalr_sel, rs1_data_i, byp_i.ex_data, byp_i.wb_data);

  ////////////////////
  // Targets
  ////////////////////

  // Branch target and JAL target share one adder
  assign bch_target = pc_i + ctrl_i.imm;
  assign jalr_sum   = jalr_fw + ctrl_i.imm;

  // JALR clears bit 0 of the sum
  assign jmp_target_o = ctrl_i.jmpr ? {jalr_sum[XLEN-1:1], 1'b0} : bch_target;

  ////////////////////
  // Operand muxes
  ////////////////////

  always_comb begin : operand_a_mux
    case (ctrl_i.op_a_sel)
      OP_A_PC:   operand_a_o = pc_i;
      OP_A_ZERO: operand_a_o = '0;
      // NONE is never loaded downstream
      default:   operand_a_o = rs1_fw;
    endcase
  end

  always_comb begin : operand_b_mux
    case (ctrl_i.op_b_sel)
      OP_B_IMM:    operand_b_o = ctrl_i.imm;
      OP_B_PCINCR: operand_b_o = PC_INCR;
      default:     operand_b_o = rs2_fw;
    endcase
  end

  // Store data or branch target
  always_comb begin : operand_c_mux
    case (ctrl_i.op_c_sel)
      OP_C_BCH: operand_c_o = bch_target;
      default:  operand_c_o = rs2_fw;
    endcase
  end

endmodule

//--- logic/id_ex_reg.sv
// ID/EX pipeline register with valid/ready handshake and enable-gated field loads
`timescale 1ns/1ps

module id_ex_reg import id_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  word_t     pc_i,
  input  dec_ctrl_t ctrl_i,
  input  word_t     operand_a_i,
  input  word_t     operand_b_i,
  input  word_t     operand_c_i,
  output id_ex_t    id_ex_o,
  output logic      out_valid_o,
  input  logic      out_ready_i
);

  logic accept;

  // Room when empty or when EX drains this cycle
  assign in_ready_o = !out_valid_o || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin : pipe_regs
    if (!rst_n) begin
      out_valid_o <= 1'b0;
      id_ex_o     <= '0;
      id_ex_o.alu_op <= ALU_SLTU;
    end else begin
      if (accept) begin
        out_valid_o <= 1'b1;

        // Enables always follow the new instruction
        id_ex_o.alu_en  <= ctrl_i.alu_en;
        id_ex_o.lsu_en  <= ctrl_i.lsu_en;
        id_ex_o.rf_we   <= ctrl_i.rf_we;
        id_ex_o.illegal <= ctrl_i.illegal;
        id_ex_o.pc      <= pc_i;

        // Unit fields only toggle when the unit is used
        if (ctrl_i.alu_en) begin
          id_ex_o.alu_op <= ctrl_i.alu_op;
          id_ex_o.bch    <= ctrl_i.bch;
          id_ex_o.jmp    <= ctrl_i.jmp;
        end
        if (ctrl_i.lsu_en) begin
          id_ex_o.lsu_we   <= ctrl_i.lsu_we;
          id_ex_o.lsu_size <= ctrl_i.lsu_size;
          id_ex_o.lsu_sext <= ctrl_i.lsu_sext;
        end
        if (ctrl_i.rf_we) begin
          id_ex_o.rf_waddr <= ctrl_i.rf_waddr;
        end

        // Unused operands keep their value
        if (ctrl_i.op_a_sel != OP_A_NONE) begin
          id_ex_o.operand_a <= operand_a_i;
        end
        if (ctrl_i.op_b_sel != OP_B_NONE) begin
          id_ex_o.operand_b <= operand_b_i;
        end
        if (ctrl_i.op_c_sel != OP_C_NONE) begin
          id_ex_o.operand_c <= operand_c_i;
        end
      end else if (out_ready_i) begin
        // Drained with nothing new behind it
        out_valid_o <= 1'b0;
      end
    end
  end

endmodule

//--- logic/id_stage.sv
// Decode stage top, connects decoder, operand selection and the ID/EX register
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  // Fetch side
  input  if_id_t     if_id_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,

  // Register file read ports
  output logic [1:0] rf_re_o,
  output rf_addr_t   rf_raddr_o [2],
  input  word_t      rf_rdata_i [2],

  // Hazard controller
  input  byp_t       byp_i,

  // Jump target towards fetch
  output word_t      jmp_target_o,

  // EX side
  output id_ex_t     id_ex_o,
  output logic       out_valid_o,
  input  logic       out_ready_i
);

  dec_ctrl_t ctrl;
  word_t     operand_a;
  word_t     operand_b;
  word_t     operand_c;

  // Source indices straight from the instruction word
  assign rf_raddr_o[0] = if_id_i.instr[RS1_MSB:RS1_LSB];
  assign rf_raddr_o[1] = if_id_i.instr[RS2_MSB:RS2_LSB];

  ////////////////////
  // Decode
  ////////////////////

  id_decoder id_decoder_i (
    .instr_i ( if_id_i.instr ),
    .ctrl_o  ( ctrl          ),
    .rf_re_o ( rf_re_o       )
  );

  ////////////////////
  // Operands
  ////////////////////

  id_operand_sel id_operand_sel_i (
    .pc_i         ( if_id_i.pc    ),
    .ctrl_i       ( ctrl          ),
    .rs1_data_i   ( rf_rdata_i[0] ),
    .rs2_data_i   ( rf_rdata_i[1] ),
    .byp_i        ( byp_i         ),
    .operand_a_o  ( operand_a     ),
    .operand_b_o  ( operand_b     ),
    .operand_c_o  ( operand_c     ),
    .jmp_target_o ( jmp_target_o  )
  );

  ////////////////////
  // ID/EX register
  ////////////////////

  id_ex_reg id_ex_reg_i (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .pc_i        ( if_id_i.pc  ),
    .ctrl_i      ( ctrl        ),
    .operand_a_i ( operand_a   ),
    .operand_b_i ( operand_b   ),
    .operand_c_i ( operand_c   ),
    .id_ex_o     ( id_ex_o     ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i )
  );

endmodule

//--- dv/id_stage_checker.sv
// Handshake and reset assertions for the decode stage, bound into every id_stage instance
`timescale 1ns/1ps

module id_stage_checker import id_pkg::*; (
  input logic   clk,
  input logic   rst_n,
  input logic   in_ready_o,
  input id_ex_t id_ex_o,
  input logic   out_valid_o,
  input logic   out_ready_i
);

  ////////////////////
  // Handshake
  ////////////////////

  // Stalled output holds data and valid
  stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> $stable(id_ex_o) && out_valid_o)
    else $error("ID/EX output changed while stalled");

  // Ready when empty or draining
  ready_rule: assert property (@(posedge clk) disable iff (!rst_n)
    in_ready_o == (!out_valid_o || out_ready_i))
    else $error("in_ready_o does not follow the output handshake");

  ////////////////////
  // Reset state
  ////////////////////

  reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> !out_valid_o && id_ex_o.alu_op == ALU_SLTU && !id_ex_o.alu_en
                     && !id_ex_o.lsu_en && !id_ex_o.rf_we && id_ex_o.operand_a == '0)
    else $error("ID/EX register not in reset state after reset");

endmodule

bind id_stage id_stage_checker id_stage_checker_i (
  .clk         ( clk         ),
  .rst_n       ( rst_n       ),
  .in_ready_o  ( in_ready_o  ),
  .id_ex_o     ( id_ex_o     ),
  .out_valid_o ( out_valid_o ),
  .out_ready_i ( out_ready_i )
);

//--- dv/id_stage_tb.sv
// Testbench for the decode stage, drives random instructions under back-pressure and checks a model
`timescale 1ns/1ps

module id_stage_tb import id_pkg::*; ();

  // Transaction counts of all tests together
  localparam int unsigned TOTAL_TXN      = 340;
  localparam int unsigned TIMEOUT_CYCLES = TOTAL_TXN * 8 + 100;

  // Instruction classes the generator picks from
  typedef enum int {
    CLS_OP, CLS_OP_IMM, CLS_LUI, CLS_AUIPC, CLS_LOAD,
    CLS_STORE, CLS_BRANCH, CLS_JAL, CLS_JALR, CLS_ILLEGAL
  } instr_cls_e;

  logic       clk;
  logic       rst_n;
  if_id_t     if_id;
  logic       in_valid;
  logic       in_ready;
  logic [1:0] rf_re;
  rf_addr_t   rf_raddr [2];
  word_t      rf_rdata [2];
  byp_t       byp;
  word_t      jmp_target;
  id_ex_t     id_ex;
  logic       out_valid;
  logic       out_ready;

  // Register file contents, x0 stays zero
  word_t       rf_mem [32];
  // Expected outputs in acceptance order
  id_ex_t      exp_q [$];
  // Model copy of the ID/EX register
  id_ex_t      model_state;
  instr_cls_e  cur_cls;
  logic        sampled_accept;
  int unsigned errors;
  int unsigned checks;
  int unsigned cycles;

  always #2 clk = ~clk;

  id_stage id_stage_i (
    .clk          ( clk        ),
    .rst_n        ( rst_n      ),
    .if_id_i      ( if_id      ),
    .in_valid_i   ( in_valid   ),
    .in_ready_o   ( in_ready   ),
    .rf_re_o      ( rf_re      ),
    .rf_raddr_o   ( rf_raddr   ),
    .rf_rdata_i   ( rf_rdata   ),
    .byp_i        ( byp        ),
    .jmp_target_o ( jmp_target ),
    .id_ex_o      ( id_ex      ),
    .out_valid_o  ( out_valid  ),
    .out_ready_i  ( out_ready  )
  );

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_id_ex(input id_ex_t got, input id_ex_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: id_ex_o = %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input rf_addr_t got, input rf_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic word_t sign_ext(input word_t v, input int unsigned width);
    return word_t'($signed(v << (XLEN - width)) >>> (XLEN - width));
  endfunction

  // Immediate as the ISA defines it for each class
  function automatic word_t class_imm(input word_t w, input instr_cls_e cls);
    case (cls)
      CLS_STORE:            return sign_ext({w[31:25], w[11:7]}, 12);
      CLS_BRANCH:           return sign_ext({w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
      CLS_LUI, CLS_AUIPC:   return {w[31:12], 12'h000};
      CLS_JAL:              return sign_ext({w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
      default:              return sign_ext(w[31:20], 12);
    endcase
  endfunction

  function automatic word_t forwarded(input fw_sel_e sel, input word_t rf_val);
    if (sel == FW_EX) return byp.ex_data;
    if (sel == FW_WB) return byp.wb_data;
    return rf_val;
  endfunction

  // Source registers each class reads, illegal reads both
  function automatic logic [1:0] exp_rf_re(input instr_cls_e cls);
    case (cls)
      CLS_OP, CLS_STORE, CLS_BRANCH, CLS_ILLEGAL: return 2'b11;
      CLS_OP_IMM, CLS_LOAD, CLS_JALR:             return 2'b01;
      default:                                    return 2'b00;
    endcase
  endfunction

  function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic b30,
                                             input logic is_reg);
    case (f3)
      3'd0:    return (is_reg && b30) ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return b30 ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Applies one accepted instruction to the model register and queues the result
  task automatic model_accept();
    word_t      w;
    word_t      pc;
    word_t      imm;
    word_t      rs1v;
    word_t      rs2v;
    logic [2:0] f3;
    logic       alu_en;
    logic       lsu_en;
    logic       rf_we;
    logic       illegal;
    logic       bch;
    logic       jmp;
    logic       lsu_we;
    alu_op_e    alu_op;
    logic       use_a;
    logic       use_b;
    logic       use_c;
    word_t      opa;
    word_t      opb;
    word_t      opc;
    w    = if_id.instr;
    pc   = if_id.pc;
    f3   = w[14:12];
    imm  = class_imm(w, cur_cls);
    rs1v = forwarded(byp.a_sel, rf_mem[w[19:15]]);
    rs2v = forwarded(byp.b_sel, rf_mem[w[24:20]]);
    {alu_en, lsu_en, rf_we, illegal, bch, jmp, lsu_we, use_a, use_b, use_c} = '0;
    alu_op = ALU_ADD;
    opa    = rs1v;
    opb    = imm;
    opc    = rs2v;
    case (cur_cls)
      CLS_OP, CLS_OP_IMM: begin
        {alu_en, rf_we, use_a, use_b} = 4'b1111;
        alu_op = alu_from_funct(f3, w[30], cur_cls == CLS_OP);
        if (cur_cls == CLS_OP) opb = rs2v;
      end
      CLS_LUI, CLS_AUIPC: begin
        {alu_en, rf_we, use_a, use_b} = 4'b1111;
        opa = (cur_cls == CLS_LUI) ? '0 : pc;
      end
      CLS_LOAD, CLS_STORE: begin
        {lsu_en, use_a, use_b} = 3'b111;
        lsu_we = (cur_cls == CLS_STORE);
        rf_we  = !lsu_we;
        use_c  = lsu_we;
      end
      CLS_BRANCH: begin
        {alu_en, bch, use_a, use_b, use_c} = 5'b11111;
        opb = rs2v;
        opc = pc + imm;
        case (f3)
          3'd0:    alu_op = ALU_EQ;
          3'd1:    alu_op = ALU_NE;
          3'd4:    alu_op = ALU_LT;
          3'd5:    alu_op = ALU_GE;
          3'd6:    alu_op = ALU_LTU;
          default: alu_op = ALU_GEU;
        endcase
      end
      CLS_JAL, CLS_JALR: begin
        {alu_en, jmp, rf_we, use_a, use_b} = 5'b11111;
        opa = pc;
        opb = 32'd4;
      end
      default: illegal = 1'b1;
    endcase
    // Enables and pc always load, unit fields only with their unit
    model_state.alu_en  = alu_en;
    model_state.lsu_en  = lsu_en;
    model_state.rf_we   = rf_we;
    model_state.illegal = illegal;
    model_state.pc      = pc;
    if (alu_en) begin
      model_state.alu_op = alu_op;
      model_state.bch    = bch;
      model_state.jmp    = jmp;
    end
    if (lsu_en) begin
      model_state.lsu_we   = lsu_we;
      model_state.lsu_size = (f3[1:0] == 2'b00) ? LSU_BYTE :
                             (f3[1:0] == 2'b01) ? LSU_HALF : LSU_WORD;
      model_state.lsu_sext = !lsu_we && !f3[2];
    end
    if (rf_we) model_state.rf_waddr = w[11:7];
    if (use_a) model_state.operand_a = opa;
    if (use_b) model_state.operand_b = opb;
    if (use_c) model_state.operand_c = opc;
    exp_q.push_back(model_state);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic word_t make_instr(input instr_cls_e cls);
    word_t       w;
    logic  [2:0] f3;
    int unsigned pick;
    w    = $urandom();
    f3   = w[14:12];
    pick = $urandom_range(0, 4);
    case (cls)
      CLS_OP: begin
        w[6:0]   = OPC_OP;
        w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && w[30]) ? 7'h20 : 7'h00;
      end
      CLS_OP_IMM: begin
        w[6:0] = OPC_OP_IMM;
        if (f3 == 3'd1) w[31:25] = 7'h00;
        else if (f3 == 3'd5) w[31:25] = w[30] ? 7'h20 : 7'h00;
      end
      CLS_LUI:    w[6:0] = OPC_LUI;
      CLS_AUIPC:  w[6:0] = OPC_AUIPC;
      // LB, LH, LW, LBU, LHU
      CLS_LOAD: begin
        w[6:0]   = OPC_LOAD;
        w[14:12] = (pick < 3) ? 3'(pick) : 3'(pick + 1);
      end
      CLS_STORE: begin
        w[6:0]   = OPC_STORE;
        w[14:12] = 3'($urandom_range(0, 2));
      end
      CLS_BRANCH: begin
        w[6:0]   = OPC_BRANCH;
        pick     = $urandom_range(0, 5);
        w[14:12] = (pick < 2) ? 3'(pick) : 3'(pick + 2);
      end
      CLS_JAL:    w[6:0] = OPC_JAL;
      CLS_JALR: begin
        w[6:0]   = OPC_JALR;
        w[14:12] = 3'd0;
      end
      default: begin
        // System, M extension, bad branch or load funct3, compressed
        case (pick)
          0: w[6:0] = 7'h73;
          1: {w[31:25], w[6:0]} = {7'h01, OPC_OP};
          2: {w[14:12], w[6:0]} = {2'b01, w[12], OPC_BRANCH};
          3: {w[14:12], w[6:0]} = {w[14], 2'b11, OPC_LOAD};
          default: w[1:0] = 2'b00;
        endcase
      end
    endcase
    return w;
  endfunction

  function automatic byp_t random_byp(input logic fwd);
    byp_t b;
    b.ex_data  = $urandom();
    b.wb_data  = $urandom();
    b.a_sel    = fwd ? fw_sel_e'($urandom_range(0, 2)) : FW_REGFILE;
    b.b_sel    = fwd ? fw_sel_e'($urandom_range(0, 2)) : FW_REGFILE;
    b.jalr_sel = fwd ? fw_sel_e'($urandom_range(0, 2)) : FW_REGFILE;
    return b;
  endfunction

  // Sends count instructions of the masked classes, then waits until all have left
  task automatic run_test(input string name, input logic [9:0] mask, input int unsigned count,
                          input int unsigned ready_pct, input logic fwd);
    int unsigned sent;
    int unsigned err_start;
    logic        hold;
    instr_cls_e  cls;
    word_t       w;
    sent      = 0;
    err_start = errors;
    while (1) begin
      @(posedge clk);
      hold = in_valid && !sampled_accept;
      out_ready <= ($urandom_range(0, 99) < ready_pct);
      byp       <= random_byp(fwd);
      if (hold) begin
        // Fetch keeps the stalled instruction
      end else if (sent < count && $urandom_range(0, 9) < 7) begin
        do cls = instr_cls_e'($urandom_range(0, 9)); while (!mask[cls]);
        w = make_instr(cls);
        if_id.instr <= w;
        if_id.pc    <= $urandom() & ~32'h3;
        rf_rdata[0] <= rf_mem[w[19:15]];
        rf_rdata[1] <= rf_mem[w[24:20]];
        cur_cls     <= cls;
        in_valid    <= 1'b1;
        sent++;
      end else begin
        in_valid <= 1'b0;
        if (sent == count && exp_q.size() == 0) break;
      end
    end
    $display("test %s: %0d instructions, %0d errors", name, count, errors - err_start);
  endtask

  ////////////////////
  // Monitor
  ////////////////////

  always @(negedge clk) begin : monitor
    word_t      base;
    logic [1:0] re_exp;
    if (rst_n) begin
      // The register holds at most one instruction
      check_bit("out_valid_o", out_valid, exp_q.size() != 0);
      if (in_valid) begin
        re_exp = exp_rf_re(cur_cls);
        check_bit("rf_re_o[0]", rf_re[0], re_exp[0]);
        check_bit("rf_re_o[1]", rf_re[1], re_exp[1]);
        // Read addresses are the rs1 and rs2 fields
        check_addr("rf_raddr_o[0]", rf_raddr[0], if_id.instr[19:15]);
        check_addr("rf_raddr_o[1]", rf_raddr[1], if_id.instr[24:20]);
        if (cur_cls == CLS_JAL) begin
          check_word("jmp_target_o", jmp_target,
                     if_id.pc + class_imm(if_id.instr, CLS_JAL));
        end else if (cur_cls == CLS_JALR) begin
          base = forwarded(byp.jalr_sel, rf_mem[if_id.instr[19:15]]);
          check_word("jmp_target_o", jmp_target,
                     (base + class_imm(if_id.instr, CLS_JALR)) & ~32'h1);
        end
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("output transfer at %0t with no instruction outstanding", $time);
        end else begin
          check_id_ex(id_ex, exp_q.pop_front());
        end
      end
      sampled_accept = in_valid && in_ready;
      if (sampled_accept) model_accept();
    end else begin
      sampled_accept = 1'b0;
    end
  end

  always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin : main
    clk            = 1'b0;
    rst_n          = 1'b0;
    in_valid       = 1'b0;
    out_ready      = 1'b0;
    if_id          = '0;
    byp            = '0;
    rf_rdata[0]    = '0;
    rf_rdata[1]    = '0;
    cur_cls        = CLS_ILLEGAL;
    sampled_accept = 1'b0;
    errors         = 0;
    checks         = 0;
    cycles         = 0;
    void'($urandom(36));
    // Reset values of the register
    model_state        = '0;
    model_state.alu_op = ALU_SLTU;
    for (int i = 0; i < 32; i++) begin
      rf_mem[i] = (i == 0) ? '0 : $urandom();
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    run_test("alu", 10'b0000001111, 60, 80, 1'b0);
    run_test("load_store", 10'b0000110000, 50, 80, 1'b0);
    run_test("branch_jump", 10'b0111000000, 50, 80, 1'b0);
    run_test("forwarding", 10'b0111111111, 60, 80, 1'b1);
    run_test("illegal", 10'b1000000000, 40, 80, 1'b1);
    run_test("backpressure", 10'b1111111111, 80, 30, 1'b1);

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
logic/id_pkg.sv
logic/id_decoder.sv
logic/id_operand_sel.sv
logic/id_ex_reg.sv
logic/id_stage.sv
dv/id_stage_checker.sv
dv/id_stage_tb.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - files:
      - logic/id_pkg.sv
      - logic/id_decoder.sv
      - logic/id_operand_sel.sv
      - logic/id_ex_reg.sv
      - logic/id_stage.sv
  - target: test
    files:
      - dv/id_stage_checker.sv
      - dv/id_stage_tb.sv
